// ==== bench/robCases.txt ====
# E slot sqN tag nm fid comp adv | W port sqN flags pc adv | P id addr adv | I sqN adv | T n
# C slot sqN tag nm pc replay | R dstPC halt fence flags src | S curSqN maxSqN flush (hex)
S 00 1f 0
P 1 00001000 1
P 2 00002000 1
# Reverse writeback, then one group commit
C 0 00 10 01 00001000 0
C 1 01 11 02 00001004 0
C 2 02 12 03 00001006 0
E 0 00 10 01 1 0 0
E 1 01 11 02 1 0 0
E 2 02 12 03 1 0 1
W 0 02 0 00001006 1
W 0 01 0 00001004 1
W 0 00 0 00001000 4
S 03 22 0
# Trap in the middle commits alone
C 0 03 20 04 00002000 0
C 0 04 21 05 00002002 0
C 0 05 22 06 00002004 0
R 00000100 0 0 2 00002002
E 0 03 20 04 2 0 0
E 1 04 21 05 2 0 0
E 2 05 22 06 2 0 1
W 0 05 0 00002004 1
W 0 04 2 00002002 1
W 0 03 0 00002000 5
S 06 25 0
# Break, fence and exception
C 0 06 30 07 00001002 0
C 0 07 31 08 00001004 0
C 0 08 32 09 00001006 0
R 00001004 1 0 2 00002002
R 00001008 0 1 2 00002002
R 00000100 0 0 3 00001006
E 0 06 30 07 1 1 0
E 1 07 31 08 1 0 0
E 2 08 32 09 1 0 1
W 0 06 1 00001002 1
W 0 07 4 00001004 1
W 0 08 3 00001006 5
S 09 28 0
# Mispredict at sqN 0b, replay then normal commit, then reused sqNs
C 0 09 40 0a 00002000 1
C 1 0a 41 0b 00002002 1
C 2 0b 42 0c 00002006 1
C 0 09 40 0a 00002000 0
C 1 0a 41 0b 00002002 0
C 2 0b 42 0c 00002006 0
C 0 0c 50 0d 00001000 0
C 0 0d 51 0e 00001004 0
E 0 09 40 0a 2 0 0
E 1 0a 41 0b 2 0 0
E 2 0b 42 0c 2 0 1
E 0 0c 43 0d 2 0 0
E 1 0d 44 0e 2 0 1
W 0 0a 0 00002002 1
I 0b 0
W 0 09 0 00002000 0
W 1 0b 0 00002006 0
W 2 0c 0 00002004 4
E 0 0c 50 0d 1 0 0
E 1 0d 51 0e 1 0 1
W 0 0d 0 00001004 1
W 0 0c 0 00001000 5
S 0e 2d 0

// ==== list.f ====
hw/robPkg.sv
hw/pcFile.sv
hw/reorderBuffer.sv
hw/commitRedirect.sv
hw/robTop.sv
bench/robTb.sv

// ==== bench/robTb.sv ====
`timescale 1ns/1ps

module robTb;
    import robPkg::*;

    localparam int robLength   = 32;
    localparam int commitWidth = 3;
    localparam int wbWidth     = 3;
    localparam time period     = 40;

    logic clk;
    logic rst;
    RenamedUOp enqUOp[commitWidth];
    ResultUOp wbUOp[wbWidth];
    logic invalidate;
    SqN_t invalidateSqN;
    logic pcWrite;
    FetchID_t pcWriteId;
    logic [31:0] pcWriteAddr;
    logic [31:0] irqAddr;
    SqN_t curSqN;
    SqN_t maxSqN;
    CommitUOp comUOp[commitWidth];
    logic mispredFlush;
    BranchProv branch;
    logic halt;
    logic fence;
    Flags irqFlags;
    logic [31:0] irqSrc;

    // Expected commit in the slot where it must appear
    typedef struct packed {
        logic [1:0] slot;
        SqN_t sqN;
        Tag_t tag;
        RegName_t nm;
        logic [31:0] pc;
        logic replay;
    } ExpCommit;

    typedef struct packed {
        logic [31:0] dstPC;
        logic halt;
        logic fence;
        Flags flags;
        logic [31:0] src;
    } ExpRedirect;

    ExpCommit commitQ[$];
    ExpRedirect redirectQ[$];
    int errors;
    int unexpected;
    int missing;
    int lineCount;
    logic casesCounted;

    // Fetch ID each sqN was enqueued with
    FetchID_t enqFetchId[2 ** $bits(SqN_t)];

    // Slot 0 commit of the previous cycle, the source of a redirect
    logic prevCommitValid;
    SqN_t prevCommitSqN;

    robTop #(
        .robLength(robLength),
        .commitWidth(commitWidth),
        .wbWidth(wbWidth)
    ) u_robTop (
        .clk(clk),
        .rst(rst),
        .enqUOp(enqUOp),
        .wbUOp(wbUOp),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .pcWrite(pcWrite),
        .pcWriteId(pcWriteId),
        .pcWriteAddr(pcWriteAddr),
        .irqAddr(irqAddr),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .comUOp(comUOp),
        .mispredFlush(mispredFlush),
        .branch(branch),
        .halt(halt),
        .fence(fence),
        .irqFlags(irqFlags),
        .irqSrc(irqSrc)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task compareField(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
        if (expVal !== actVal) begin
            errors++;
            $display("Fail %0t %s expected %h actual %h", $time, name, expVal, actVal);
        end
    endtask

    task clearStrobes();
        for (int i = 0; i < commitWidth; i++) begin
            enqUOp[i] = '0;
        end
        for (int j = 0; j < wbWidth; j++) begin
            wbUOp[j] = '0;
        end
        invalidate = 1'b0;
        pcWrite = 1'b0;
    endtask

    // Strobes last one cycle before the bus goes quiet
    task advance(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            @(negedge clk);
            clearStrobes();
        end
    endtask

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin : checkOutputs
        ExpCommit ec;
        ExpRedirect er;
        logic causeValid;
        SqN_t causeSqN;
        if (!rst) begin
            causeValid = prevCommitValid;
            causeSqN = prevCommitSqN;
            prevCommitValid = 1'b0;
            for (int i = 0; i < commitWidth; i++) begin
                if (comUOp[i].valid) begin
                    if (commitQ.size() == 0) begin
                        unexpected++;
                        $display("Unexpected commit of sqN %h in slot %0d at %0t",
                            comUOp[i].sqN, i, $time);
                    end else begin
                        ec = commitQ.pop_front();
                        compareField("comUOp.slot", ec.slot, i);
                        compareField("comUOp.sqN", ec.sqN, comUOp[i].sqN);
                        compareField("comUOp.tagDst", ec.tag, comUOp[i].tagDst);
                        compareField("comUOp.nmDst", ec.nm, comUOp[i].nmDst);
                        compareField("comUOp.pc", ec.pc, comUOp[i].pc);
                        compareField("comUOp.replay", ec.replay, comUOp[i].replay);
                        compareField("mispredFlush", ec.replay, mispredFlush);
                        if (i == 0) begin
                            prevCommitValid = 1'b1;
                            prevCommitSqN = ec.sqN;
                        end
                    end
                end
            end
            if (branch.taken) begin
                if (redirectQ.size() == 0) begin
                    unexpected++;
                    $display("Unexpected redirect to %h at %0t", branch.dstPC, $time);
                end else begin
                    er = redirectQ.pop_front();
                    compareField("branch.dstPC", er.dstPC, branch.dstPC);
                    compareField("halt", er.halt, halt);
                    compareField("fence", er.fence, fence);
                    compareField("irqFlags", er.flags, irqFlags);
                    compareField("irqSrc", er.src, irqSrc);
                    if (!causeValid) begin
                        errors++;
                        $display("Redirect at %0t does not follow a slot 0 commit", $time);
                    end else begin
                        compareField("branch.sqN", causeSqN, branch.sqN);
                        compareField("branch.fetchID", enqFetchId[causeSqN], branch.fetchID);
                    end
                end
            end else if (halt || fence) begin
                unexpected++;
                $display("Halt or fence pulsed without a redirect at %0t", $time);
            end
        end
    end

    initial begin : runCases
        int fd;
        int code;
        logic [63:0] cmd;
        logic [8*256-1:0] lineBuf;
        logic [31:0] f[7];
        ExpCommit ec;
        ExpRedirect er;
        rst = 1'b1;
        clearStrobes();
        invalidateSqN = '0;
        pcWriteId = '0;
        pcWriteAddr = '0;
        irqAddr = 32'h0000_0100;
        errors = 0;
        unexpected = 0;
        missing = 0;
        lineCount = 0;
        casesCounted = 1'b0;
        prevCommitValid = 1'b0;
        prevCommitSqN = '0;
        fd = $fopen("bench/robCases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file");
            $display("** FAIL **");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(lineBuf, fd);
                if (code > 0) begin
                    lineCount++;
                end
            end
            $fclose(fd);
            casesCounted = 1'b1;
            fd = $fopen("bench/robCases.txt", "r");
            repeat (16) @(negedge clk);
            rst = 1'b0;
            while ($fscanf(fd, "%s", cmd) == 1) begin
                case (cmd)
                    "#": code = $fgets(lineBuf, fd);
                    "P": begin
                        code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                        pcWrite = 1'b1;
                        pcWriteId = f[0];
                        pcWriteAddr = f[1];
                        advance(f[2]);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                        enqUOp[f[0]].sqN = f[1];
                        enqUOp[f[0]].tagDst = f[2];
                        enqUOp[f[0]].nmDst = f[3];
                        enqUOp[f[0]].fetchID = f[4];
                        enqUOp[f[0]].compressed = f[5][0];
                        enqUOp[f[0]].valid = 1'b1;
                        enqFetchId[f[1][5:0]] = f[4][3:0];
                        advance(f[6]);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                        wbUOp[f[0]].sqN = f[1];
                        wbUOp[f[0]].flags = Flags'(f[2][2:0]);
                        wbUOp[f[0]].pc = f[3];
                        wbUOp[f[0]].valid = 1'b1;
                        advance(f[4]);
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h", f[0], f[1]);
                        invalidate = 1'b1;
                        invalidateSqN = f[0];
                        advance(f[1]);
                    end
                    "T": begin
                        code = $fscanf(fd, "%h", f[0]);
                        advance(f[0]);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5]);
                        ec = {f[0][1:0], f[1][5:0], f[2][6:0], f[3][4:0], f[4], f[5][0]};
                        commitQ.push_back(ec);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                        er = {f[0], f[1][0], f[2][0], f[3][2:0], f[4]};
                        redirectQ.push_back(er);
                    end
                    "S": begin
                        code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                        compareField("curSqN", f[0], curSqN);
                        compareField("maxSqN", f[1], maxSqN);
                        compareField("mispredFlush", f[2], mispredFlush);
                    end
                    default: begin
                        errors++;
                        $display("Unknown command in the case file");
                    end
                endcase
            end
            $fclose(fd);
            advance(8);
            missing = commitQ.size() + redirectQ.size();
            if (missing > 0) begin
                $display("%0d expected commits or redirects never appeared", missing);
            end
            $display("errors %0d, unexpected %0d, missing %0d", errors, unexpected, missing);
            if (errors + unexpected + missing == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // Each case line gets a generous budget of clock periods
    initial begin : watchdog
        wait (casesCounted);
        #(lineCount * 20 * period);
        $display("Timeout, the case file did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== hw/robTop.sv ====
`timescale 1ns/1ps

module robTop #(
    parameter int robLength   = 32,
    parameter int commitWidth = 3,
    parameter int wbWidth     = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  robPkg::RenamedUOp  enqUOp[commitWidth],
    input  robPkg::ResultUOp   wbUOp[wbWidth],
    input  logic               invalidate,
    input  robPkg::SqN_t       invalidateSqN,
    input  logic               pcWrite,
    input  robPkg::FetchID_t   pcWriteId,
    input  logic [31:0]        pcWriteAddr,
    input  logic [31:0]        irqAddr,
    output robPkg::SqN_t       curSqN,
    output robPkg::SqN_t       maxSqN,
    output robPkg::CommitUOp   comUOp[commitWidth],
    output logic               mispredFlush,
    output robPkg::BranchProv  branch,
    output logic               halt,
    output logic               fence,
    output robPkg::Flags       irqFlags,
    output logic [31:0]        irqSrc
);
    import robPkg::*;

    // Combinational PC lookup per commit slot
    FetchID_t pcReadId[commitWidth];
    logic [31:0] pcReadData[commitWidth];

    pcFile #(
        .commitWidth(commitWidth)
    ) u_pcFile (
        .clk(clk),
        .rst(rst),
        .pcWrite(pcWrite),
        .pcWriteId(pcWriteId),
        .pcWriteAddr(pcWriteAddr),
        .readId(pcReadId),
        .readData(pcReadData)
    );

    reorderBuffer #(
        .robLength(robLength),
        .commitWidth(commitWidth),
        .wbWidth(wbWidth)
    ) u_reorderBuffer (
        .clk(clk),
        .rst(rst),
        .enqUOp(enqUOp),
        .wbUOp(wbUOp),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .pcReadId(pcReadId),
        .pcReadData(pcReadData),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .comUOp(comUOp),
        .mispredFlush(mispredFlush)
    );

    // Flagged ops only ever commit in slot 0
    commitRedirect u_commitRedirect (
        .clk(clk),
        .rst(rst),
        .comUOp0(comUOp[0]),
        .irqAddr(irqAddr),
        .branch(branch),
        .halt(halt),
        .fence(fence),
        .irqFlags(irqFlags),
        .irqSrc(irqSrc)
    );

endmodule

// ==== hw/commitRedirect.sv ====
`timescale 1ns/1ps

module commitRedirect (
    input  logic               clk,
    input  logic               rst,
    input  robPkg::CommitUOp   comUOp0,
    input  logic [31:0]        irqAddr,
    output robPkg::BranchProv  branch,
    output logic               halt,
    output logic               fence,
    output robPkg::Flags       irqFlags,
    output logic [31:0]        irqSrc
);
    import robPkg::*;

    logic [31:0] nextPC;
    logic flagged;

    assign nextPC = comUOp0.pc + (comUOp0.compressed ? 32'd2 : 32'd4);

    // Replayed ops are rollback traffic and never redirect
    assign flagged = comUOp0.valid && !comUOp0.replay && comUOp0.flags != FLAGS_NONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            branch.taken <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;
            irqFlags <= FLAGS_NONE;
            irqSrc <= '0;
        end else begin
            branch.taken <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;

            if (flagged) begin
                branch.taken <= 1'b1;
                branch.sqN <= comUOp0.sqN;
                branch.fetchID <= comUOp0.fetchID;
                branch.flush <= 1'b1;
                case (comUOp0.flags)
                    FLAGS_BRK: begin
                        // Resume after the ebreak so the debugger sees its effect
                        branch.dstPC <= nextPC;
                        halt <= 1'b1;
                    end
                    FLAGS_TRAP, FLAGS_EXCEPT: begin
                        branch.dstPC <= irqAddr;
                        irqFlags <= comUOp0.flags;
                        irqSrc <= comUOp0.pc;
                    end
                    default: begin
                        // Fence restarts fetch behind itself
                        branch.dstPC <= nextPC;
                        fence <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== hw/reorderBuffer.sv ====
`timescale 1ns/1ps

module reorderBuffer #(
    parameter int robLength   = 32,
    parameter int commitWidth = 3,
    parameter int wbWidth     = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  robPkg::RenamedUOp  enqUOp[commitWidth],
    input  robPkg::ResultUOp   wbUOp[wbWidth],
    input  logic               invalidate,
    input  robPkg::SqN_t       invalidateSqN,
    output robPkg::FetchID_t   pcReadId[commitWidth],
    input  logic [31:0]        pcReadData[commitWidth],
    output robPkg::SqN_t       curSqN,
    output robPkg::SqN_t       maxSqN,
    output robPkg::CommitUOp   comUOp[commitWidth],
    output logic               mispredFlush
);
    import robPkg::*;

    localparam int idxBits = $clog2(robLength);

    typedef struct packed {
        SqN_t sqN;
        Tag_t tag;
        RegName_t name;
        FetchID_t fetchID;
        FetchOff_t fetchOff;
        Flags flags;
        logic isBranch;
        logic branchTaken;
        logic compressed;
        logic valid;
        logic executed;
    } RobEntry;

    typedef enum logic [1:0] {
        RP_IDLE,
        RP_REPLAY,
        RP_DRAIN
    } ReplayState;

    RobEntry entries[robLength];
    SqN_t baseIndex;

    ReplayState replayState;
    SqN_t replayIter;
    SqN_t replayEndSqN;

    SqN_t slotSqN[commitWidth];
    RobEntry slotEntry[commitWidth];
    CommitUOp slotUOp[commitWidth];
    logic replayInRange[commitWidth];
    logic replayLast;
    logic groupReady;
    logic singleReady;

    logic younger[robLength];
    logic wbAccept[wbWidth];

    assign curSqN = baseIndex;
    assign maxSqN = baseIndex + SqN_t'(robLength - 1);

    // Slots start at the head, or at the replay pointer while rolling back
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            if (replayState == RP_REPLAY) begin
                slotSqN[i] = replayIter + SqN_t'(i);
            end else begin
                slotSqN[i] = baseIndex + SqN_t'(i);
            end
            slotEntry[i] = entries[slotSqN[i][idxBits-1:0]];
            pcReadId[i] = slotEntry[i].fetchID;

            slotUOp[i].valid       = slotEntry[i].valid;
            slotUOp[i].sqN         = slotSqN[i];
            slotUOp[i].tagDst      = slotEntry[i].tag;
            slotUOp[i].nmDst       = slotEntry[i].name;
            // Block base plus the halfword offset
            slotUOp[i].pc          = pcReadData[i] + {29'b0, slotEntry[i].fetchOff, 1'b0};
            slotUOp[i].isBranch    = slotEntry[i].isBranch;
            slotUOp[i].branchTaken = slotEntry[i].branchTaken;
            slotUOp[i].compressed  = slotEntry[i].compressed;
            slotUOp[i].flags       = slotEntry[i].flags;
            slotUOp[i].fetchID     = slotEntry[i].fetchID;
            slotUOp[i].replay      = (replayState == RP_REPLAY);

            replayInRange[i] = $signed(SqN_t'(slotSqN[i] - replayEndSqN)) <= 0;
        end
        // Last slot reaches the branch, so this is the final replay cycle
        replayLast = $signed(SqN_t'(slotSqN[commitWidth-1] - replayEndSqN)) >= 0;
    end

    // Group commit needs every head op done and free of flags
    always_comb begin
        groupReady = 1'b1;
        for (int i = 0; i < commitWidth; i++) begin
            if (!slotEntry[i].valid || !slotEntry[i].executed
                    || slotEntry[i].flags != FLAGS_NONE) begin
                groupReady = 1'b0;
            end
        end
        singleReady = slotEntry[0].valid && slotEntry[0].executed;
    end

    always_comb begin
        for (int k = 0; k < robLength; k++) begin
            younger[k] = $signed(SqN_t'(entries[k].sqN - invalidateSqN)) > 0;
        end
        // Writebacks up to the branch still land in the invalidate cycle
        for (int j = 0; j < wbWidth; j++) begin
            wbAccept[j] = wbUOp[j].valid && (!invalidate
                || $signed(SqN_t'(wbUOp[j].sqN - invalidateSqN)) <= 0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            replayState <= RP_IDLE;
            mispredFlush <= 1'b0;
            for (int k = 0; k < robLength; k++) begin
                entries[k].valid <= 1'b0;
                entries[k].executed <= 1'b0;
            end
            for (int i = 0; i < commitWidth; i++) begin
                comUOp[i].valid <= 1'b0;
                comUOp[i].replay <= 1'b0;
            end
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                comUOp[i].valid <= 1'b0;
                comUOp[i].replay <= 1'b0;
            end

            if (invalidate) begin
                for (int k = 0; k < robLength; k++) begin
                    if (younger[k]) begin
                        entries[k].valid <= 1'b0;
                        entries[k].executed <= 1'b0;
                    end
                end
                replayState <= RP_REPLAY;
                replayIter <= baseIndex;
                replayEndSqN <= invalidateSqN;
                mispredFlush <= 1'b0;
            end else begin
                case (replayState)
                    RP_REPLAY: begin
                        // Replay head to branch so rename can roll back its map
                        mispredFlush <= 1'b1;
                        for (int i = 0; i < commitWidth; i++) begin
                            comUOp[i] <= slotUOp[i];
                            if (!replayInRange[i]) begin
                                comUOp[i].valid <= 1'b0;
                            end
                        end
                        replayIter <= replayIter + SqN_t'(commitWidth);
                        if (replayLast) begin
                            replayState <= RP_DRAIN;
                        end
                    end
                    RP_DRAIN: begin
                        mispredFlush <= 1'b0;
                        replayState <= RP_IDLE;
                    end
                    default: begin
                        if (groupReady) begin
                            for (int i = 0; i < commitWidth; i++) begin
                                comUOp[i] <= slotUOp[i];
                                entries[slotSqN[i][idxBits-1:0]].valid <= 1'b0;
                                entries[slotSqN[i][idxBits-1:0]].executed <= 1'b0;
                            end
                            baseIndex <= baseIndex + SqN_t'(commitWidth);
                        end else if (singleReady) begin
                            // Flagged ops always leave alone through slot 0
                            comUOp[0] <= slotUOp[0];
                            entries[slotSqN[0][idxBits-1:0]].valid <= 1'b0;
                            entries[slotSqN[0][idxBits-1:0]].executed <= 1'b0;
                            baseIndex <= baseIndex + SqN_t'(1);
                        end
                    end
                endcase

                // Enqueue from rename, dropped in the invalidate cycle
                for (int i = 0; i < commitWidth; i++) begin
                    if (enqUOp[i].valid) begin
                        entries[enqUOp[i].sqN[idxBits-1:0]].valid      <= 1'b1;
                        entries[enqUOp[i].sqN[idxBits-1:0]].executed   <= 1'b0;
                        entries[enqUOp[i].sqN[idxBits-1:0]].sqN        <= enqUOp[i].sqN;
                        entries[enqUOp[i].sqN[idxBits-1:0]].tag        <= enqUOp[i].tagDst;
                        entries[enqUOp[i].sqN[idxBits-1:0]].name       <= enqUOp[i].nmDst;
                        entries[enqUOp[i].sqN[idxBits-1:0]].fetchID    <= enqUOp[i].fetchID;
                        entries[enqUOp[i].sqN[idxBits-1:0]].compressed <= enqUOp[i].compressed;
                    end
                end
            end

            // Writeback marks executed and records outcome
            for (int j = 0; j < wbWidth; j++) begin
                if (wbAccept[j]) begin
                    entries[wbUOp[j].sqN[idxBits-1:0]].executed    <= 1'b1;
                    entries[wbUOp[j].sqN[idxBits-1:0]].flags       <= wbUOp[j].flags;
                    entries[wbUOp[j].sqN[idxBits-1:0]].isBranch    <= wbUOp[j].isBranch;
                    entries[wbUOp[j].sqN[idxBits-1:0]].branchTaken <= wbUOp[j].branchTaken;
                    entries[wbUOp[j].sqN[idxBits-1:0]].fetchOff    <= wbUOp[j].pc[2:1];
                end
            end
        end
    end

endmodule

// ==== hw/pcFile.sv ====
`timescale 1ns/1ps

module pcFile #(
    parameter int commitWidth = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pcWrite,
    input  robPkg::FetchID_t  pcWriteId,
    input  logic [31:0]       pcWriteAddr,
    input  robPkg::FetchID_t  readId[commitWidth],
    output logic [31:0]       readData[commitWidth]
);
    import robPkg::*;

    localparam int numBlocks = 2 ** $bits(FetchID_t);

    // Blocks are 8-byte aligned, so the low address bits are not stored
    logic [31:3] blockBase[numBlocks];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < numBlocks; k++) begin
                blockBase[k] <= '0;
            end
        end else if (pcWrite) begin
            blockBase[pcWriteId] <= pcWriteAddr[31:3];
        end
    end

    // One combinational read port per commit slot
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            readData[i] = {blockBase[readId[i]], 3'b000};
        end
    end

endmodule

// ==== hw/robPkg.sv ====
package robPkg;

    // Sequence number, low bits index the reorder buffer
    typedef logic [5:0] SqN_t;

    // Physical result tag
    typedef logic [6:0] Tag_t;

    // Architectural destination register
    typedef logic [4:0] RegName_t;

    // Fetch block index into the PC file
    typedef logic [3:0] FetchID_t;

    // Halfword offset inside an 8-byte fetch block
    typedef logic [1:0] FetchOff_t;

    typedef enum logic [2:0] {
        FLAGS_NONE,
        FLAGS_BRK,
        FLAGS_TRAP,
        FLAGS_EXCEPT,
        FLAGS_FENCE
    } Flags;

    // Rename to reorder buffer
    typedef struct packed {
        SqN_t sqN;
        Tag_t tagDst;
        RegName_t nmDst;
        FetchID_t fetchID;
        logic compressed;
        logic valid;
    } RenamedUOp;

    // Execution units to reorder buffer
    typedef struct packed {
        SqN_t sqN;
        Tag_t tagDst;
        RegName_t nmDst;
        Flags flags;
        logic isBranch;
        logic branchTaken;
        logic [31:0] pc;
        logic compressed;
        logic valid;
    } ResultUOp;

    // Commit slot output, replay marks mispredict rollback ops
    typedef struct packed {
        logic valid;
        SqN_t sqN;
        Tag_t tagDst;
        RegName_t nmDst;
        logic [31:0] pc;
        logic isBranch;
        logic branchTaken;
        logic compressed;
        Flags flags;
        FetchID_t fetchID;
        logic replay;
    } CommitUOp;

    // Redirect of the front end
    typedef struct packed {
        logic taken;
        logic [31:0] dstPC;
        SqN_t sqN;
        FetchID_t fetchID;
        logic flush;
    } BranchProv;

endpackage
